// ==== files.f ====
logic/rob_types_pkg.sv
logic/rob_tag_pkg.sv
logic/rob_alloc_ctrl.sv
logic/rob_entry_store.sv
logic/rob_commit_ctrl.sv
logic/rob_read_forward.sv
logic/rob_top.sv
verif/rob_props.sv
verif/rob_tb.sv

// ==== logic/rob_alloc_ctrl.sv ====
`timescale 1ns/1ps

module rob_alloc_ctrl #(
    parameter  int DEPTH = 16,
    localparam int IDX_W = $clog2(DEPTH),
    localparam int CNT_W = IDX_W + 1
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             alloc_en_0,
    input  logic             alloc_en_1,
    input  logic [CNT_W-1:0] count,
    output logic             alloc_success,
    output logic             alloc_fire_0,
    output logic             alloc_fire_1,
    output logic [IDX_W-1:0] alloc_idx_0,
    output logic [IDX_W-1:0] alloc_idx_1,
    output logic [CNT_W-1:0] tail_ptr
);

    logic [1:0]       num_req;
    logic [CNT_W-1:0] free_slots;

    // ========================================
    // Room check
    // ========================================
    assign num_req    = {1'b0, alloc_en_0} + {1'b0, alloc_en_1};
    assign free_slots = CNT_W'(DEPTH) - count;

    // All or nothing, a partial grant would break the lane order
    assign alloc_success = (free_slots >= CNT_W'(num_req));

    assign alloc_fire_0 = alloc_en_0 && alloc_success;
    assign alloc_fire_1 = alloc_en_1 && alloc_success;

    // Lane 1 sits behind lane 0 only when lane 0 is in use
    assign alloc_idx_0 = tail_ptr[IDX_W-1:0];
    assign alloc_idx_1 = tail_ptr[IDX_W-1:0] + IDX_W'(alloc_en_0);

    // ========================================
    // Tail pointer
    // ========================================

    // Extra MSB is the wrap bit, so tail - head gives the occupancy directly
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            tail_ptr <= '0;
        end else begin
            tail_ptr <= tail_ptr + CNT_W'(alloc_fire_0) + CNT_W'(alloc_fire_1);
        end
    end

endmodule

// ==== logic/rob_commit_ctrl.sv ====
`timescale 1ns/1ps

module rob_commit_ctrl #(
    parameter  int DEPTH = 16,
    localparam int IDX_W = $clog2(DEPTH),
    localparam int CNT_W = IDX_W + 1
) (
    input  logic             clk,
    input  logic             reset,
    input  logic [CNT_W-1:0] tail_ptr,
    input  logic             head_exec_0,
    input  logic             head_exec_1,
    output logic [IDX_W-1:0] head_idx,
    output logic [1:0]       retire_count,
    output logic [CNT_W-1:0] count,
    output logic             full,
    output logic             empty,
    output logic             commit_valid_0,
    output logic             commit_valid_1
);

    logic [CNT_W-1:0] head_ptr;   // Wrap bit on top, like the tail

    // ========================================
    // Occupancy
    // ========================================

    // Modulo 2*DEPTH subtraction, the wrap bits resolve the full case
    assign count = tail_ptr - head_ptr;
    assign empty = (count == '0);
    assign full  = (count == CNT_W'(DEPTH));

    assign head_idx = head_ptr[IDX_W-1:0];

    // ========================================
    // In-order retire
    // ========================================

    // Second slot retires only behind the first one
    assign commit_valid_0 = !empty && head_exec_0;
    assign commit_valid_1 = commit_valid_0 && (count >= CNT_W'(2)) && head_exec_1;

    assign retire_count = {1'b0, commit_valid_0} + {1'b0, commit_valid_1};

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            head_ptr <= '0;
        end else begin
            head_ptr <= head_ptr + CNT_W'(retire_count);
        end
    end

endmodule

// ==== logic/rob_entry_store.sv ====
`timescale 1ns/1ps

module rob_entry_store
    import rob_types_pkg::*;
    import rob_tag_pkg::*;
#(
    parameter  int DEPTH = 16,
    localparam int IDX_W = $clog2(DEPTH)
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             alloc_fire_0,
    input  logic             alloc_fire_1,
    input  logic [IDX_W-1:0] alloc_idx_0,
    input  logic [IDX_W-1:0] alloc_idx_1,
    input  tag_t             alloc_tag_0,
    input  tag_t             alloc_tag_1,
    input  dest_reg_t        alloc_dest_0,
    input  dest_reg_t        alloc_dest_1,
    input  logic             cdb_valid_0,
    input  logic             cdb_valid_1,
    input  logic [IDX_W-1:0] cdb_idx_0,
    input  logic [IDX_W-1:0] cdb_idx_1,
    input  data_t            cdb_data_0,
    input  data_t            cdb_data_1,
    input  logic             cdb_exc_0,
    input  logic             cdb_exc_1,
    input  logic [IDX_W-1:0] head_idx,
    input  logic [1:0]       retire_count,
    input  logic [IDX_W-1:0] read_idx_0,
    input  logic [IDX_W-1:0] read_idx_1,
    output logic             head_exec_0,
    output logic             head_exec_1,
    output data_t            commit_data_0,
    output data_t            commit_data_1,
    output dest_reg_t        commit_dest_0,
    output dest_reg_t        commit_dest_1,
    output logic             commit_exc_0,
    output logic             commit_exc_1,
    output tag_t             stored_tag_0,
    output tag_t             stored_tag_1,
    output data_t            stored_data_0,
    output data_t            stored_data_1
);

    data_t            entry_data [DEPTH];
    tag_t             entry_tag  [DEPTH];
    dest_reg_t        entry_dest [DEPTH];
    logic [DEPTH-1:0] entry_exec;
    logic [DEPTH-1:0] entry_exc;       // Exception or misprediction seen

    logic [IDX_W-1:0] head_idx_1;

    assign head_idx_1 = head_idx + 1'b1;   // Wraps with the index width

    // ========================================
    // Entry updates
    // ========================================
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                entry_data[i] <= '0;
                entry_tag[i]  <= '0;
                entry_dest[i] <= '0;
            end
            entry_exec <= '0;
            entry_exc  <= '0;
        end else begin
            // New entries start unexecuted and wait on their tag
            if (alloc_fire_0) begin
                entry_data[alloc_idx_0] <= '0;
                entry_tag[alloc_idx_0]  <= alloc_tag_0;
                entry_dest[alloc_idx_0] <= alloc_dest_0;
                entry_exec[alloc_idx_0] <= 1'b0;
                entry_exc[alloc_idx_0]  <= 1'b0;
            end
            if (alloc_fire_1) begin
                entry_data[alloc_idx_1] <= '0;
                entry_tag[alloc_idx_1]  <= alloc_tag_1;
                entry_dest[alloc_idx_1] <= alloc_dest_1;
                entry_exec[alloc_idx_1] <= 1'b0;
                entry_exc[alloc_idx_1]  <= 1'b0;
            end

            // A lane only lands on an entry that waits on that lane
            if (cdb_valid_0 && entry_tag[cdb_idx_0] == TAG_LANE0) begin
                entry_data[cdb_idx_0] <= cdb_data_0;
                entry_tag[cdb_idx_0]  <= TAG_READY;
                entry_exec[cdb_idx_0] <= 1'b1;
                entry_exc[cdb_idx_0]  <= cdb_exc_0;
            end
            if (cdb_valid_1 && entry_tag[cdb_idx_1] == TAG_LANE1) begin
                entry_data[cdb_idx_1] <= cdb_data_1;
                entry_tag[cdb_idx_1]  <= TAG_READY;
                entry_exec[cdb_idx_1] <= 1'b1;
                entry_exc[cdb_idx_1]  <= cdb_exc_1;
            end

            // Retiring entries are cleared on the edge that moves the head
            if (retire_count != 2'd0) begin
                entry_data[head_idx] <= '0;
                entry_tag[head_idx]  <= '0;
                entry_dest[head_idx] <= '0;
                entry_exec[head_idx] <= 1'b0;
                entry_exc[head_idx]  <= 1'b0;
            end
            if (retire_count == 2'd2) begin
                entry_data[head_idx_1] <= '0;
                entry_tag[head_idx_1]  <= '0;
                entry_dest[head_idx_1] <= '0;
                entry_exec[head_idx_1] <= 1'b0;
                entry_exc[head_idx_1]  <= 1'b0;
            end
        end
    end

    // ========================================
    // Head and read views
    // ========================================
    assign head_exec_0   = entry_exec[head_idx];
    assign head_exec_1   = entry_exec[head_idx_1];
    assign commit_data_0 = entry_data[head_idx];
    assign commit_data_1 = entry_data[head_idx_1];
    assign commit_dest_0 = entry_dest[head_idx];
    assign commit_dest_1 = entry_dest[head_idx_1];
    assign commit_exc_0  = entry_exc[head_idx];
    assign commit_exc_1  = entry_exc[head_idx_1];

    assign stored_tag_0  = entry_tag[read_idx_0];
    assign stored_tag_1  = entry_tag[read_idx_1];
    assign stored_data_0 = entry_data[read_idx_0];
    assign stored_data_1 = entry_data[read_idx_1];

endmodule

// ==== logic/rob_read_forward.sv ====
`timescale 1ns/1ps

module rob_read_forward
    import rob_types_pkg::*;
    import rob_tag_pkg::*;
#(
    parameter  int DEPTH = 16,
    localparam int IDX_W = $clog2(DEPTH)
) (
    input  logic             cdb_valid_0,
    input  logic             cdb_valid_1,
    input  logic [IDX_W-1:0] cdb_idx_0,
    input  logic [IDX_W-1:0] cdb_idx_1,
    input  data_t            cdb_data_0,
    input  data_t            cdb_data_1,
    input  logic [IDX_W-1:0] read_idx_0,
    input  logic [IDX_W-1:0] read_idx_1,
    input  tag_t             stored_tag_0,
    input  tag_t             stored_tag_1,
    input  data_t            stored_data_0,
    input  data_t            stored_data_1,
    output tag_t             read_tag_0,
    output tag_t             read_tag_1,
    output data_t            read_data_0,
    output data_t            read_data_1
);

    // One read port: bus result of this cycle first, lane 1 over lane 0
    function automatic void select_port(
        input  logic [IDX_W-1:0] idx,
        input  tag_t             s_tag,
        input  data_t            s_data,
        output tag_t             tag,
        output data_t            data
    );
        if (cdb_valid_1 && cdb_idx_1 == idx) begin
            tag  = TAG_READY;
            data = cdb_data_1;
        end else if (cdb_valid_0 && cdb_idx_0 == idx) begin
            tag  = TAG_READY;
            data = cdb_data_0;
        end else begin
            tag  = s_tag;     // Stored entry, as of the last edge
            data = s_data;
        end
    endfunction

    always_comb begin
        select_port(read_idx_0, stored_tag_0, stored_data_0, read_tag_0, read_data_0);
    end

    always_comb begin
        select_port(read_idx_1, stored_tag_1, stored_data_1, read_tag_1, read_data_1);
    end

endmodule

// ==== logic/rob_tag_pkg.sv ====
package rob_tag_pkg;

    import rob_types_pkg::*;

    // An entry waits on exactly one lane, named by its stored tag
    localparam tag_t TAG_LANE0 = 3'd0;  // Written only by bus lane 0
    localparam tag_t TAG_LANE1 = 3'd1;  // Written only by bus lane 1

    // Entry executed, stored data is valid for consumers
    localparam tag_t TAG_READY = 3'd7;

endpackage

// ==== logic/rob_top.sv ====
`timescale 1ns/1ps

module rob_top
    import rob_types_pkg::*;
#(
    parameter  int DEPTH = 16,
    localparam int IDX_W = $clog2(DEPTH),
    localparam int CNT_W = IDX_W + 1
) (
    input  logic             clk,
    input  logic             reset,
    // Allocation
    input  logic             alloc_en_0,
    input  logic             alloc_en_1,
    input  tag_t             alloc_tag_0,
    input  tag_t             alloc_tag_1,
    input  dest_reg_t        alloc_dest_0,
    input  dest_reg_t        alloc_dest_1,
    output logic             alloc_success,
    // Result bus
    input  logic             cdb_valid_0,
    input  logic             cdb_valid_1,
    input  logic [IDX_W-1:0] cdb_idx_0,
    input  logic [IDX_W-1:0] cdb_idx_1,
    input  data_t            cdb_data_0,
    input  data_t            cdb_data_1,
    input  logic             cdb_exc_0,
    input  logic             cdb_exc_1,
    // Reservation-station reads
    input  logic [IDX_W-1:0] read_idx_0,
    input  logic [IDX_W-1:0] read_idx_1,
    output tag_t             read_tag_0,
    output tag_t             read_tag_1,
    output data_t            read_data_0,
    output data_t            read_data_1,
    // Retire
    output logic             commit_valid_0,
    output logic             commit_valid_1,
    output data_t            commit_data_0,
    output data_t            commit_data_1,
    output dest_reg_t        commit_dest_0,
    output dest_reg_t        commit_dest_1,
    output logic             commit_exc_0,
    output logic             commit_exc_1,
    // Status
    output logic [CNT_W-1:0] count,
    output logic             full,
    output logic             empty
);

    // ========================================
    // Internal wiring
    // ========================================
    logic             alloc_fire_0;
    logic             alloc_fire_1;
    logic [IDX_W-1:0] alloc_idx_0;
    logic [IDX_W-1:0] alloc_idx_1;
    logic [CNT_W-1:0] tail_ptr;
    logic [IDX_W-1:0] head_idx;
    logic [1:0]       retire_count;
    logic             head_exec_0;
    logic             head_exec_1;
    tag_t             stored_tag_0;
    tag_t             stored_tag_1;
    data_t            stored_data_0;
    data_t            stored_data_1;

    rob_alloc_ctrl #(.DEPTH(DEPTH)) u_alloc (
        .clk           (clk),
        .reset         (reset),
        .alloc_en_0    (alloc_en_0),
        .alloc_en_1    (alloc_en_1),
        .count         (count),
        .alloc_success (alloc_success),
        .alloc_fire_0  (alloc_fire_0),
        .alloc_fire_1  (alloc_fire_1),
        .alloc_idx_0   (alloc_idx_0),
        .alloc_idx_1   (alloc_idx_1),
        .tail_ptr      (tail_ptr)
    );

    rob_entry_store #(.DEPTH(DEPTH)) u_store (
        .clk           (clk),
        .reset         (reset),
        .alloc_fire_0  (alloc_fire_0),
        .alloc_fire_1  (alloc_fire_1),
        .alloc_idx_0   (alloc_idx_0),
        .alloc_idx_1   (alloc_idx_1),
        .alloc_tag_0   (alloc_tag_0),
        .alloc_tag_1   (alloc_tag_1),
        .alloc_dest_0  (alloc_dest_0),
        .alloc_dest_1  (alloc_dest_1),
        .cdb_valid_0   (cdb_valid_0),
        .cdb_valid_1   (cdb_valid_1),
        .cdb_idx_0     (cdb_idx_0),
        .cdb_idx_1     (cdb_idx_1),
        .cdb_data_0    (cdb_data_0),
        .cdb_data_1    (cdb_data_1),
        .cdb_exc_0     (cdb_exc_0),
        .cdb_exc_1     (cdb_exc_1),
        .head_idx      (head_idx),
        .retire_count  (retire_count),
        .read_idx_0    (read_idx_0),
        .read_idx_1    (read_idx_1),
        .head_exec_0   (head_exec_0),
        .head_exec_1   (head_exec_1),
        .commit_data_0 (commit_data_0),
        .commit_data_1 (commit_data_1),
        .commit_dest_0 (commit_dest_0),
        .commit_dest_1 (commit_dest_1),
        .commit_exc_0  (commit_exc_0),
        .commit_exc_1  (commit_exc_1),
        .stored_tag_0  (stored_tag_0),
        .stored_tag_1  (stored_tag_1),
        .stored_data_0 (stored_data_0),
        .stored_data_1 (stored_data_1)
    );

    rob_commit_ctrl #(.DEPTH(DEPTH)) u_commit (
        .clk            (clk),
        .reset          (reset),
        .tail_ptr       (tail_ptr),
        .head_exec_0    (head_exec_0),
        .head_exec_1    (head_exec_1),
        .head_idx       (head_idx),
        .retire_count   (retire_count),
        .count          (count),
        .full           (full),
        .empty          (empty),
        .commit_valid_0 (commit_valid_0),
        .commit_valid_1 (commit_valid_1)
    );

    rob_read_forward #(.DEPTH(DEPTH)) u_read (
        .cdb_valid_0   (cdb_valid_0),
        .cdb_valid_1   (cdb_valid_1),
        .cdb_idx_0     (cdb_idx_0),
        .cdb_idx_1     (cdb_idx_1),
        .cdb_data_0    (cdb_data_0),
        .cdb_data_1    (cdb_data_1),
        .read_idx_0    (read_idx_0),
        .read_idx_1    (read_idx_1),
        .stored_tag_0  (stored_tag_0),
        .stored_tag_1  (stored_tag_1),
        .stored_data_0 (stored_data_0),
        .stored_data_1 (stored_data_1),
        .read_tag_0    (read_tag_0),
        .read_tag_1    (read_tag_1),
        .read_data_0   (read_data_0),
        .read_data_1   (read_data_1)
    );

endmodule

// ==== logic/rob_types_pkg.sv ====
package rob_types_pkg;

    // ========================================
    // Field widths
    // ========================================
    localparam int DATA_W = 32;
    localparam int TAG_W  = 3;
    localparam int DEST_W = 5;

    // ========================================
    // Entry field types
    // ========================================

    // Result value, written by the result bus and retired to the register file
    typedef logic [DATA_W-1:0] data_t;

    // Producer tag: one code per result-bus lane, plus the ready code
    typedef logic [TAG_W-1:0] tag_t;

    // Architectural register that the retiring instruction writes
    typedef logic [DEST_W-1:0] dest_reg_t;

endpackage

// ==== verif/rob_props.sv ====
`timescale 1ns/1ps

module rob_props
    import rob_types_pkg::*;
#(
    parameter  int DEPTH = 16,
    localparam int CNT_W = $clog2(DEPTH) + 1
) (
    input logic             clk,
    input logic             reset,
    input logic             alloc_en_0,
    input logic             alloc_en_1,
    input logic             alloc_success,
    input logic [CNT_W-1:0] count,
    input logic             full,
    input logic             commit_valid_0,
    input logic             commit_valid_1
);

    logic [1:0] granted;
    logic [1:0] retired;

    // Requests only count when the whole group was accepted
    assign granted = alloc_success ? ({1'b0, alloc_en_0} + {1'b0, alloc_en_1}) : 2'd0;
    assign retired = {1'b0, commit_valid_0} + {1'b0, commit_valid_1};

    // ========================================
    // Occupancy and back-pressure rules
    // ========================================
    count_bound: assert property (@(posedge clk) disable iff (!reset)
        count <= CNT_W'(DEPTH))
        else $error("count 0x%0h is above the buffer depth", count);

    // Occupancy moves by what was allocated minus what retired
    count_step: assert property (@(posedge clk) disable iff (!reset)
        count == $past(count) + CNT_W'($past(granted)) - CNT_W'($past(retired)))
        else $error("count 0x%0h does not follow the last allocations and retires", count);

    full_refuses: assert property (@(posedge clk) disable iff (!reset)
        full && (alloc_en_0 || alloc_en_1) |-> !alloc_success)
        else $error("allocation accepted while the buffer is full");

endmodule

bind rob_top rob_props #(.DEPTH(DEPTH)) u_props (
    .clk            (clk),
    .reset          (reset),
    .alloc_en_0     (alloc_en_0),
    .alloc_en_1     (alloc_en_1),
    .alloc_success  (alloc_success),
    .count          (count),
    .full           (full),
    .commit_valid_0 (commit_valid_0),
    .commit_valid_1 (commit_valid_1)
);

// ==== verif/rob_tb.sv ====
`timescale 1ns/1ps

module rob_tb
    import rob_types_pkg::*;
    import rob_tag_pkg::*;
();

    localparam int DEPTH = 16;
    localparam int IDX_W = $clog2(DEPTH);
    localparam int CNT_W = IDX_W + 1;

    // One cycle of stimulus with the outputs expected in that cycle
    typedef struct packed {
        logic [1:0]            alloc_en;
        tag_t [1:0]            alloc_tag;
        dest_reg_t [1:0]       alloc_dest;
        logic [1:0]            cdb_valid;
        logic [1:0][IDX_W-1:0] cdb_idx;
        data_t [1:0]           cdb_data;
        logic [1:0]            cdb_exc;
        logic [1:0][IDX_W-1:0] read_idx;
        tag_t [1:0]            exp_read_tag;
        data_t [1:0]           exp_read_data;
        logic [1:0]            exp_commit;      // Commit fields checked only where set
        data_t [1:0]           exp_commit_data;
        dest_reg_t [1:0]       exp_commit_dest;
        logic [1:0]            exp_commit_exc;
        logic [CNT_W-1:0]      exp_count;
        logic                  exp_full;
        logic                  exp_empty;
        logic                  exp_success;
    } row_t;

    logic clk;
    logic reset;
    logic alloc_en_0, alloc_en_1;
    tag_t alloc_tag_0, alloc_tag_1;
    dest_reg_t alloc_dest_0, alloc_dest_1;
    logic alloc_success;
    logic cdb_valid_0, cdb_valid_1;
    logic [IDX_W-1:0] cdb_idx_0, cdb_idx_1;
    data_t cdb_data_0, cdb_data_1;
    logic cdb_exc_0, cdb_exc_1;
    logic [IDX_W-1:0] read_idx_0, read_idx_1;
    tag_t read_tag_0, read_tag_1;
    data_t read_data_0, read_data_1;
    logic commit_valid_0, commit_valid_1;
    data_t commit_data_0, commit_data_1;
    dest_reg_t commit_dest_0, commit_dest_1;
    logic commit_exc_0, commit_exc_1;
    logic [CNT_W-1:0] count;
    logic full;
    logic empty;

    row_t stim [$];
    row_t cur;
    int   errors = 0;
    int   row_num = 0;
    bit   stim_ready = 1'b0;

    rob_top #(.DEPTH(DEPTH)) u_rob_top (.*);

    always #5 clk = ~clk;

    // ========================================
    // Row building
    // ========================================
    task automatic alloc_lane(input int lane, input tag_t tag, input dest_reg_t dest);
        cur.alloc_en[lane]   = 1'b1;
        cur.alloc_tag[lane]  = tag;
        cur.alloc_dest[lane] = dest;
    endtask

    task automatic result_lane(input int lane, input logic [IDX_W-1:0] idx,
                               input data_t data, input logic exc);
        cur.cdb_valid[lane] = 1'b1;
        cur.cdb_idx[lane]   = idx;
        cur.cdb_data[lane]  = data;
        cur.cdb_exc[lane]   = exc;
    endtask

    task automatic read_port(input int port, input logic [IDX_W-1:0] idx,
                             input tag_t tag, input data_t data);
        cur.read_idx[port]      = idx;
        cur.exp_read_tag[port]  = tag;
        cur.exp_read_data[port] = data;
    endtask

    task automatic expect_commit(input int lane, input data_t data,
                                 input dest_reg_t dest, input logic exc);
        cur.exp_commit[lane]      = 1'b1;
        cur.exp_commit_data[lane] = data;
        cur.exp_commit_dest[lane] = dest;
        cur.exp_commit_exc[lane]  = exc;
    endtask

    task automatic push_row(input logic [CNT_W-1:0] cnt, input logic f,
                            input logic e, input logic ok);
        cur.exp_count   = cnt;
        cur.exp_full    = f;
        cur.exp_empty   = e;
        cur.exp_success = ok;
        stim.push_back(cur);
        cur = '0;
    endtask

    task automatic build_stimulus();
        cur = '0;
        // Dual allocations, entries 0..3
        alloc_lane(0, TAG_LANE0, 5'd5);
        alloc_lane(1, TAG_LANE1, 5'd6);
        push_row(0, 1'b0, 1'b1, 1'b1);
        alloc_lane(0, TAG_LANE1, 5'd7);
        alloc_lane(1, TAG_LANE0, 5'd8);
        read_port(0, 0, TAG_LANE0, '0);
        read_port(1, 1, TAG_LANE1, '0);
        push_row(2, 1'b0, 1'b0, 1'b1);
        result_lane(0, 1, 32'hdead_beef, 1'b1);     // Entry 1 waits on lane 1
        read_port(0, 2, TAG_LANE1, '0);
        read_port(1, 3, TAG_LANE0, '0);
        push_row(4, 1'b0, 1'b0, 1'b1);
        read_port(0, 1, TAG_LANE1, '0);
        push_row(4, 1'b0, 1'b0, 1'b1);
        // Entry 1 executes ahead of the head
        result_lane(1, 1, 32'h1111_0001, 1'b1);
        read_port(0, 1, TAG_READY, 32'h1111_0001);
        push_row(4, 1'b0, 1'b0, 1'b1);
        result_lane(0, 2, 32'haaaa_0002, 1'b0);
        result_lane(1, 2, 32'hbbbb_0002, 1'b0);
        read_port(0, 1, TAG_READY, 32'h1111_0001);
        read_port(1, 2, TAG_READY, 32'hbbbb_0002);
        push_row(4, 1'b0, 1'b0, 1'b1);
        result_lane(0, 0, 32'h0000_00a0, 1'b1);
        read_port(0, 0, TAG_READY, 32'h0000_00a0);
        read_port(1, 2, TAG_READY, 32'hbbbb_0002);
        push_row(4, 1'b0, 1'b0, 1'b1);
        expect_commit(0, 32'h0000_00a0, 5'd5, 1'b1);
        expect_commit(1, 32'h1111_0001, 5'd6, 1'b1);
        read_port(0, 3, TAG_LANE0, '0);
        read_port(1, 3, TAG_LANE0, '0);
        push_row(4, 1'b0, 1'b0, 1'b1);
        expect_commit(0, 32'hbbbb_0002, 5'd7, 1'b0); // Entry 3 still pending
        push_row(2, 1'b0, 1'b0, 1'b1);
        result_lane(0, 3, 32'h0000_00c3, 1'b0);
        read_port(0, 3, TAG_READY, 32'h0000_00c3);
        read_port(1, 2, '0, '0);
        push_row(1, 1'b0, 1'b0, 1'b1);
        expect_commit(0, 32'h0000_00c3, 5'd8, 1'b0);
        read_port(0, 3, TAG_READY, 32'h0000_00c3);
        read_port(1, 4, '0, '0);
        push_row(1, 1'b0, 1'b0, 1'b1);
        // Fill all 16 entries, each row reads the pair of the row before
        for (int k = 0; k < 8; k++) begin
            alloc_lane(0, TAG_LANE1, dest_reg_t'(2 * k));
            alloc_lane(1, TAG_LANE1, dest_reg_t'(2 * k + 1));
            read_port(0, IDX_W'(2 + 2 * k), (k == 0) ? tag_t'(0) : TAG_LANE1, '0);
            read_port(1, IDX_W'(3 + 2 * k), (k == 0) ? tag_t'(0) : TAG_LANE1, '0);
            push_row(CNT_W'(2 * k), 1'b0, k == 0, 1'b1);
        end
        alloc_lane(0, TAG_LANE0, 5'd9);
        read_port(0, 2, TAG_LANE1, '0);
        read_port(1, 3, TAG_LANE1, '0);
        push_row(16, 1'b1, 1'b0, 1'b0);
        alloc_lane(0, TAG_LANE0, 5'd9);
        alloc_lane(1, TAG_LANE0, 5'd10);
        read_port(0, 6, TAG_LANE1, '0);
        read_port(1, 7, TAG_LANE1, '0);
        push_row(16, 1'b1, 1'b0, 1'b0);
        read_port(0, 4, TAG_LANE1, '0);         // Refused requests left entry 4 alone
        read_port(1, 5, TAG_LANE1, '0);
        push_row(16, 1'b1, 1'b0, 1'b1);
    endtask

    // ========================================
    // Drive and check
    // ========================================
    task automatic drive_row(input row_t r);
        alloc_en_0   <= r.alloc_en[0];
        alloc_en_1   <= r.alloc_en[1];
        alloc_tag_0  <= r.alloc_tag[0];
        alloc_tag_1  <= r.alloc_tag[1];
        alloc_dest_0 <= r.alloc_dest[0];
        alloc_dest_1 <= r.alloc_dest[1];
        cdb_valid_0  <= r.cdb_valid[0];
        cdb_valid_1  <= r.cdb_valid[1];
        cdb_idx_0    <= r.cdb_idx[0];
        cdb_idx_1    <= r.cdb_idx[1];
        cdb_data_0   <= r.cdb_data[0];
        cdb_data_1   <= r.cdb_data[1];
        cdb_exc_0    <= r.cdb_exc[0];
        cdb_exc_1    <= r.cdb_exc[1];
        read_idx_0   <= r.read_idx[0];
        read_idx_1   <= r.read_idx[1];
    endtask

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("mismatch %s row %0d: got 0x%0h, expected 0x%0h",
                     name, row_num, got, exp);
        end
    endtask

    task automatic check_row(input row_t r);
        check_field("read_tag_0", read_tag_0, r.exp_read_tag[0]);
        check_field("read_tag_1", read_tag_1, r.exp_read_tag[1]);
        check_field("read_data_0", read_data_0, r.exp_read_data[0]);
        check_field("read_data_1", read_data_1, r.exp_read_data[1]);
        check_field("commit_valid_0", commit_valid_0, r.exp_commit[0]);
        check_field("commit_valid_1", commit_valid_1, r.exp_commit[1]);
        if (r.exp_commit[0]) begin
            check_field("commit_data_0", commit_data_0, r.exp_commit_data[0]);
            check_field("commit_dest_0", commit_dest_0, r.exp_commit_dest[0]);
            check_field("commit_exc_0", commit_exc_0, r.exp_commit_exc[0]);
        end
        if (r.exp_commit[1]) begin
            check_field("commit_data_1", commit_data_1, r.exp_commit_data[1]);
            check_field("commit_dest_1", commit_dest_1, r.exp_commit_dest[1]);
            check_field("commit_exc_1", commit_exc_1, r.exp_commit_exc[1]);
        end
        check_field("count", count, r.exp_count);
        check_field("full", full, r.exp_full);
        check_field("empty", empty, r.exp_empty);
        check_field("alloc_success", alloc_success, r.exp_success);
    endtask

    // ========================================
    // Main sequence
    // ========================================
    initial begin
        clk   = 1'b0;
        reset = 1'b0;
        cur   = '0;
        drive_row(cur);          // All inputs idle from time zero
        build_stimulus();
        stim_ready = 1'b1;
        repeat (8) @(posedge clk);
        reset <= 1'b1;
        foreach (stim[i]) begin
            @(posedge clk);
            row_num = i;
            drive_row(stim[i]);
            @(negedge clk);      // Mid-cycle, combinational outputs settled
            check_row(stim[i]);
        end
        $display("Checks finished: %0d rows, %0d errors", stim.size(), errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Watchdog sized from the row count plus reset and margin
    initial begin
        longint limit_ns;
        wait (stim_ready);
        limit_ns = (longint'(stim.size()) + 8 + 20) * 10;
        #(limit_ns);
        $display("Timeout: run did not finish within %0d ns", limit_ns);
        $display("Test failed");
        $finish;
    end

endmodule
